/* filelist.f */
+incdir+include
logic/trap_pkg.sv
logic/trap_ctrl.sv
logic/csr_wb_arbiter.sv
logic/csr_file.sv
logic/trap_unit_top.sv
testbench/trap_unit_tb.sv

/* include/trap_macros.svh */
// trap unit widths, csr addresses and codes

`ifndef TRAP_MACROS_SVH
`define TRAP_MACROS_SVH

// data path width
`define TRAP_XLEN 64

// machine csr addresses
`define CSR_ADR_MSTATUS 12'h300
`define CSR_ADR_MTVEC   12'h305
`define CSR_ADR_MEPC    12'h341
`define CSR_ADR_MCAUSE  12'h342

// decoder opcode codes for the trap unit
`define INST_ECALL 8'h01
`define INST_MRET  8'h02

// environment call from machine mode
`define CAUSE_ECALL_M 64'd11

`endif

/* logic/csr_file.sv */
// machine csr file, wishbone classic slave

`timescale 1ns/1ns

`include "trap_macros.svh"

module csr_file (
  input  logic              clk,
  input  logic              rst,
  input  trap_pkg::wb_req_t i_wb,
  output trap_pkg::wb_rsp_t o_wb
);

  logic [`TRAP_XLEN-1:0] mstatus_q;
  logic [`TRAP_XLEN-1:0] mepc_q;
  logic [`TRAP_XLEN-1:0] mcause_q;
  logic [`TRAP_XLEN-1:0] mtvec_q;
  logic                  ack_q;
  logic [`TRAP_XLEN-1:0] rdat_q;
  logic [`TRAP_XLEN-1:0] rd_mux;
  logic                  take;
  logic                  wr_en;
  trap_pkg::csr_word_u   wr_in;
  trap_pkg::csr_word_u   wr_mst;

  assign take  = i_wb.cyc && i_wb.stb && !ack_q;
  assign wr_en = i_wb.cyc && i_wb.stb && i_wb.we && ack_q;  // write on the ack edge

  // only mpp, mpie and mie survive a write
  always_comb begin
    wr_in.raw           = i_wb.dat;
    wr_mst.raw          = '0;
    wr_mst.mstatus.mpp  = wr_in.mstatus.mpp;
    wr_mst.mstatus.mpie = wr_in.mstatus.mpie;
    wr_mst.mstatus.mie  = wr_in.mstatus.mie;
  end

  always_comb begin
    case (i_wb.adr)
      `CSR_ADR_MSTATUS: rd_mux = mstatus_q;
      `CSR_ADR_MEPC:    rd_mux = mepc_q;
      `CSR_ADR_MCAUSE:  rd_mux = mcause_q;
      `CSR_ADR_MTVEC:   rd_mux = mtvec_q;
      default:          rd_mux = '0;  // unmapped
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q     <= 1'b0;
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtvec_q   <= '0;
    end else begin
      ack_q <= take;
      if (wr_en) begin
        case (i_wb.adr)
          `CSR_ADR_MSTATUS: mstatus_q <= wr_mst.raw;
          `CSR_ADR_MEPC:    mepc_q    <= {i_wb.dat[`TRAP_XLEN-1:1], 1'b0};
          `CSR_ADR_MCAUSE:  mcause_q  <= i_wb.dat;
          `CSR_ADR_MTVEC:   mtvec_q   <= {i_wb.dat[`TRAP_XLEN-1:2], 2'b00};  // direct mode
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take)
      rdat_q <= rd_mux;
  end

  assign o_wb = '{ack: ack_q, dat: rdat_q};

  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    o_wb.ack |=> !o_wb.ack)
    else $error("csr_file ack held for two cycles");

endmodule

/* logic/csr_wb_arbiter.sv */
// two-master wishbone arbiter, trap side first

`timescale 1ns/1ns

module csr_wb_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  trap_pkg::wb_req_t i_trap_wb,
  output trap_pkg::wb_rsp_t o_trap_wb,
  input  trap_pkg::wb_req_t i_core_wb,
  output trap_pkg::wb_rsp_t o_core_wb,
  output trap_pkg::wb_req_t o_csr_wb,
  input  trap_pkg::wb_rsp_t i_csr_wb
);

  logic [1:0] own_q;  // bit 0 trap, bit 1 core, zero when free
  logic       trap_rq;
  logic       core_rq;

  assign trap_rq = i_trap_wb.cyc && i_trap_wb.stb;
  assign core_rq = i_core_wb.cyc && i_core_wb.stb;

  always_ff @(posedge clk) begin
    if (rst) begin
      own_q <= 2'b00;
    end else if (own_q == 2'b00) begin
      if (trap_rq)
        own_q <= 2'b01;  // trap wins a tie
      else if (core_rq)
        own_q <= 2'b10;
    end else if (i_csr_wb.ack || !o_csr_wb.cyc) begin
      own_q <= 2'b00;
    end
  end

  always_comb begin
    o_csr_wb = '0;
    if (own_q[0])
      o_csr_wb = i_trap_wb;
    else if (own_q[1])
      o_csr_wb = i_core_wb;
  end

  // response only to the owner
  assign o_trap_wb = own_q[0] ? i_csr_wb : '0;
  assign o_core_wb = own_q[1] ? i_csr_wb : '0;

  a_one_ack: assert property (@(posedge clk) disable iff (rst)
    !(o_trap_wb.ack && o_core_wb.ack))
    else $error("both masters acknowledged");

  a_grant_held: assert property (@(posedge clk) disable iff (rst)
    o_csr_wb.cyc && !i_csr_wb.ack |=> $stable(own_q))
    else $error("grant moved inside a bus cycle");

endmodule

/* logic/trap_ctrl.sv */
// ecall / mret trap sequencer
// one wishbone cycle per csr access

`timescale 1ns/1ns

`include "trap_macros.svh"

module trap_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_ena,
  input  trap_pkg::trap_inst_t i_inst,
  input  logic                i_ack,
  output logic                o_req,
  output trap_pkg::jump_t     o_jump,
  output trap_pkg::wb_req_t   o_wb,
  input  trap_pkg::wb_rsp_t   i_wb
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_E_MEPC,    // write pc
    S_E_MCAUSE,  // write cause
    S_E_MTVEC,   // read handler base
    S_E_RD_MST,
    S_E_WR_MST,
    S_M_RD_MST,
    S_M_MEPC,    // read return address
    S_M_WR_MST
  } state_t;

  state_t                state_q;
  state_t                nxt_state;
  logic                  cyc_q;
  logic                  last_acc;
  logic                  accept;
  logic                  jump_valid_q;
  logic [`TRAP_XLEN-1:0] jump_addr_q;
  logic [`TRAP_XLEN-1:0] pc_q;
  trap_pkg::csr_word_u   rd_mst_q;   // mstatus as read
  logic [`TRAP_XLEN-1:0] tgt_q;      // mtvec or mepc
  trap_pkg::csr_word_u   ecall_mst;
  trap_pkg::csr_word_u   mret_mst;
  logic [11:0]           wb_adr;
  logic                  wb_we;
  logic [`TRAP_XLEN-1:0] wb_dat;

  assign accept   = (state_q == S_IDLE) && i_ena && !o_req;
  assign last_acc = (state_q == S_E_WR_MST) || (state_q == S_M_WR_MST);

  // new mstatus built through the field view
  always_comb begin
    ecall_mst = rd_mst_q;
    ecall_mst.mstatus.mpp  = 2'b11;                 // machine
    ecall_mst.mstatus.mpie = rd_mst_q.mstatus.mie;
    ecall_mst.mstatus.mie  = 1'b0;
    mret_mst = rd_mst_q;
    mret_mst.mstatus.mie  = rd_mst_q.mstatus.mpie;
    mret_mst.mstatus.mpie = 1'b1;
    mret_mst.mstatus.mpp  = 2'b00;
  end

  always_comb begin
    case (state_q)
      S_E_MEPC:   nxt_state = S_E_MCAUSE;
      S_E_MCAUSE: nxt_state = S_E_MTVEC;
      S_E_MTVEC:  nxt_state = S_E_RD_MST;
      S_E_RD_MST: nxt_state = S_E_WR_MST;
      S_M_RD_MST: nxt_state = S_M_MEPC;
      S_M_MEPC:   nxt_state = S_M_WR_MST;
      default:    nxt_state = S_IDLE;
    endcase
  end

  // access of the current state held until ack
  always_comb begin
    wb_adr = 12'h000;
    wb_we  = 1'b0;
    wb_dat = '0;
    case (state_q)
      S_E_MEPC: begin
        wb_adr = `CSR_ADR_MEPC;
        wb_we  = 1'b1;
        wb_dat = pc_q;
      end
      S_E_MCAUSE: begin
        wb_adr = `CSR_ADR_MCAUSE;
        wb_we  = 1'b1;
        wb_dat = `CAUSE_ECALL_M;
      end
      S_E_MTVEC:              wb_adr = `CSR_ADR_MTVEC;
      S_E_RD_MST, S_M_RD_MST: wb_adr = `CSR_ADR_MSTATUS;
      S_M_MEPC:               wb_adr = `CSR_ADR_MEPC;
      S_E_WR_MST: begin
        wb_adr = `CSR_ADR_MSTATUS;
        wb_we  = 1'b1;
        wb_dat = ecall_mst.raw;
      end
      S_M_WR_MST: begin
        wb_adr = `CSR_ADR_MSTATUS;
        wb_we  = 1'b1;
        wb_dat = mret_mst.raw;
      end
      default: ;
    endcase
  end

  assign o_wb   = '{cyc: cyc_q, stb: cyc_q, we: wb_we, adr: wb_adr, dat: wb_dat};
  assign o_jump = '{valid: jump_valid_q, addr: jump_addr_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= S_IDLE;
      cyc_q        <= 1'b0;
      o_req        <= 1'b0;
      jump_valid_q <= 1'b0;
    end else begin
      jump_valid_q <= 1'b0;
      if (o_req && i_ack)
        o_req <= 1'b0;  // done handshake
      if (state_q == S_IDLE) begin
        if (accept && i_inst.opcode == `INST_ECALL)
          state_q <= S_E_MEPC;
        else if (accept && i_inst.opcode == `INST_MRET)
          state_q <= S_M_RD_MST;
      end else if (!cyc_q) begin
        cyc_q <= 1'b1;  // first access one cycle after acceptance
      end else if (i_wb.ack) begin
        state_q <= nxt_state;  // cyc stays up for the next access
        if (last_acc) begin
          cyc_q        <= 1'b0;
          o_req        <= 1'b1;
          jump_valid_q <= 1'b1;
        end
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (accept)
      pc_q <= i_inst.pc;
    if (cyc_q && i_wb.ack) begin
      case (state_q)
        S_E_MTVEC, S_M_MEPC:     tgt_q        <= i_wb.dat;
        S_E_RD_MST, S_M_RD_MST:  rd_mst_q.raw <= i_wb.dat;
        S_E_WR_MST, S_M_WR_MST:  jump_addr_q  <= tgt_q;
        default: ;
      endcase
    end
  end

  // a started cycle is never abandoned
  a_cyc_until_ack: assert property (@(posedge clk) disable iff (rst)
    o_wb.cyc && !i_wb.ack |=> o_wb.cyc)
    else $error("trap_ctrl dropped cyc before ack");

endmodule

/* logic/trap_pkg.sv */
// trap unit shared types

`include "trap_macros.svh"

package trap_pkg;

  // instruction handed over by the pipeline
  typedef struct packed {
    logic [7:0]            opcode;
    logic [`TRAP_XLEN-1:0] pc;
  } trap_inst_t;

  // wishbone classic, master side
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [11:0]           adr;
    logic [`TRAP_XLEN-1:0] dat;
  } wb_req_t;

  // wishbone classic, slave side
  typedef struct packed {
    logic                  ack;
    logic [`TRAP_XLEN-1:0] dat;
  } wb_rsp_t;

  // redirect toward fetch
  typedef struct packed {
    logic                  valid;
    logic [`TRAP_XLEN-1:0] addr;
  } jump_t;

  // mstatus field view, machine mode bits only
  typedef struct packed {
    logic [`TRAP_XLEN-14:0] rsv_hi;  // 63:13
    logic [1:0]             mpp;     // 12:11
    logic [2:0]             rsv_mid;
    logic                   mpie;    // 7
    logic [2:0]             rsv_lo;
    logic                   mie;     // 3
    logic [2:0]             rsv_base;
  } mstatus_t;

  typedef union packed {
    logic [`TRAP_XLEN-1:0] raw;
    mstatus_t              mstatus;
  } csr_word_u;

endpackage

/* logic/trap_unit_top.sv */
// machine-mode trap unit top

`timescale 1ns/1ns

module trap_unit_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_ena,
  input  trap_pkg::trap_inst_t i_inst,
  input  logic                 i_ack,
  output logic                 o_req,
  output trap_pkg::jump_t      o_jump,
  input  trap_pkg::wb_req_t    i_core_wb,
  output trap_pkg::wb_rsp_t    o_core_wb
);

  trap_pkg::wb_req_t trap_wb;   // sequencer master
  trap_pkg::wb_rsp_t trap_rsp;
  trap_pkg::wb_req_t csr_wb;    // toward the csr file
  trap_pkg::wb_rsp_t csr_rsp;

  trap_ctrl u_trap_ctrl (
    .clk    (clk),
    .rst    (rst),
    .i_ena  (i_ena),
    .i_inst (i_inst),
    .i_ack  (i_ack),
    .o_req  (o_req),
    .o_jump (o_jump),
    .o_wb   (trap_wb),
    .i_wb   (trap_rsp)
  );

  csr_wb_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .i_trap_wb (trap_wb),
    .o_trap_wb (trap_rsp),
    .i_core_wb (i_core_wb),
    .o_core_wb (o_core_wb),
    .o_csr_wb  (csr_wb),
    .i_csr_wb  (csr_rsp)
  );

  csr_file u_csr_file (
    .clk  (clk),
    .rst  (rst),
    .i_wb (csr_wb),
    .o_wb (csr_rsp)
  );

endmodule

/* testbench/trap_unit_tb.sv */
// trap unit testbench
// directed tests against a csr model

`timescale 1ns/1ns

`include "trap_macros.svh"

module trap_unit_tb;

  localparam int N_TESTS   = 6;
  localparam int LIMIT_CYC = 16 + 200 * N_TESTS;  // reset plus budget per test

  logic                 clk;
  logic                 rst;
  logic                 i_ena;
  trap_pkg::trap_inst_t i_inst;
  logic                 i_ack;
  logic                 o_req;
  trap_pkg::jump_t      o_jump;
  trap_pkg::wb_req_t    i_core_wb;
  trap_pkg::wb_rsp_t    o_core_wb;

  integer      seed;
  int          errors;
  int          test_errs;
  string       cur_test;
  logic [63:0] m_mstatus;  // reference copies of the csrs
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic [63:0] m_mtvec;

  trap_unit_top DUT (
    .clk       (clk),
    .rst       (rst),
    .i_ena     (i_ena),
    .i_inst    (i_inst),
    .i_ack     (i_ack),
    .o_req     (o_req),
    .o_jump    (o_jump),
    .i_core_wb (i_core_wb),
    .o_core_wb (o_core_wb)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // watchdog
  initial begin
    repeat (LIMIT_CYC) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", LIMIT_CYC);
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic logic [63:0] rand_word();
    rand_word = {$random(seed), $random(seed)};
  endfunction

  function automatic logic [11:0] csr_adr(input int k);
    case (k)
      0:       csr_adr = `CSR_ADR_MSTATUS;
      1:       csr_adr = `CSR_ADR_MEPC;
      2:       csr_adr = `CSR_ADR_MCAUSE;
      default: csr_adr = `CSR_ADR_MTVEC;
    endcase
  endfunction

  // masking rules of the csr file
  function automatic void model_write(input logic [11:0] adr, input logic [63:0] dat);
    case (adr)
      `CSR_ADR_MSTATUS: m_mstatus = dat & 64'h1888;  // mpp, mpie, mie
      `CSR_ADR_MEPC:    m_mepc    = dat & ~64'h1;
      `CSR_ADR_MCAUSE:  m_mcause  = dat;
      `CSR_ADR_MTVEC:   m_mtvec   = dat & ~64'h3;
      default: ;
    endcase
  endfunction

  function automatic logic [63:0] model_read(input logic [11:0] adr);
    case (adr)
      `CSR_ADR_MSTATUS: model_read = m_mstatus;
      `CSR_ADR_MEPC:    model_read = m_mepc;
      `CSR_ADR_MCAUSE:  model_read = m_mcause;
      `CSR_ADR_MTVEC:   model_read = m_mtvec;
      default:          model_read = 64'h0;
    endcase
  endfunction

  // applies a trap to the model, returns the expected jump address
  function automatic logic [63:0] model_trap(input logic [7:0] op, input logic [63:0] pc);
    logic mie_old;
    model_trap = 64'h0;
    if (op == `INST_ECALL) begin
      model_write(`CSR_ADR_MEPC, pc);
      m_mcause = 64'd11;
      model_trap = m_mtvec;
      mie_old = m_mstatus[3];
      m_mstatus[12:11] = 2'b11;
      m_mstatus[7] = mie_old;
      m_mstatus[3] = 1'b0;
    end else if (op == `INST_MRET) begin
      model_trap = m_mepc;
      m_mstatus[3] = m_mstatus[7];
      m_mstatus[7] = 1'b1;
      m_mstatus[12:11] = 2'b00;
    end
  endfunction

  task automatic note_failure(input string what);
    $display("%s: %s", cur_test, what);
    errors++;
    test_errs++;
  endtask

  task automatic check_word(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_jump(input string what, input trap_pkg::jump_t exp,
                            input trap_pkg::jump_t act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %b/%h, actual %b/%h", cur_test, what,
               exp.valid, exp.addr, act.valid, act.addr);
      errors++;
      test_errs++;
    end
  endtask

  // one wishbone classic cycle on the core port
  task automatic core_cycle(input logic we, input logic [11:0] adr, input logic [63:0] dat,
                            output logic [63:0] rdat);
    @(posedge clk);
    i_core_wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do @(negedge clk); while (!o_core_wb.ack);
    rdat = o_core_wb.dat;
    @(posedge clk);
    i_core_wb <= '0;
  endtask

  task automatic core_write(input logic [11:0] adr, input logic [63:0] dat);
    logic [63:0] unused;
    core_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic core_read(input logic [11:0] adr, output logic [63:0] dat);
    core_cycle(1'b0, adr, 64'h0, dat);
  endtask

  task automatic check_csrs();
    logic [63:0] v;
    for (int k = 0; k < 4; k++) begin
      core_read(csr_adr(k), v);
      check_word($sformatf("csr %h", csr_adr(k)), model_read(csr_adr(k)), v);
    end
  endtask

  // pulse i_ena, wait for o_req, hold i_ack off, then acknowledge
  task automatic do_trap(input logic [7:0] op, input logic [63:0] pc, input int hold,
                         input bit poke, output trap_pkg::jump_t jmp);
    int pulses;
    pulses = 0;
    jmp = '0;
    @(posedge clk);
    i_ena  <= 1'b1;
    i_inst <= '{opcode: op, pc: pc};
    @(posedge clk);
    i_ena <= 1'b0;
    do begin
      @(negedge clk);
      if (o_jump.valid) begin
        pulses++;
        jmp = o_jump;
      end
    end while (!o_req);
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      i_ena  <= poke && (i == 1);  // stray request while o_req waits
      i_inst <= '{opcode: `INST_ECALL, pc: ~pc};
      @(negedge clk);
      if (!o_req)
        note_failure("o_req dropped before i_ack was given");
      if (o_jump.valid)
        pulses++;
    end
    @(posedge clk);
    i_ena <= 1'b0;
    i_ack <= 1'b1;
    @(posedge clk);
    i_ack <= 1'b0;
    @(negedge clk);
    if (o_req)
      note_failure("o_req still high after the i_ack cycle");
    check_word("jump valid pulses", 64'd1, 64'(pulses));
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    $display("test %-12s %s (%0d errors)", cur_test, (test_errs == 0) ? "ok" : "failed",
             test_errs);
  endtask

  initial begin
    trap_pkg::jump_t jmp;
    logic [63:0]     v;
    logic [63:0]     w;
    logic [63:0]     pc;
    logic [63:0]     exp;
    logic [7:0]      op;
    int              hold;
    seed = 32'h1b0d;
    errors = 0;
    test_errs = 0;
    cur_test = "reset";
    {m_mstatus, m_mepc, m_mcause, m_mtvec} = '0;
    rst = 1'b1;
    i_ena = 1'b0;
    i_inst = '0;
    i_ack = 1'b0;
    i_core_wb = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    start_test("csr_port");
    w = rand_word() | 64'h3;  // low bits set to see the masks
    core_write(`CSR_ADR_MTVEC, w);
    model_write(`CSR_ADR_MTVEC, w);
    w = rand_word() | 64'h1;
    core_write(`CSR_ADR_MEPC, w);
    model_write(`CSR_ADR_MEPC, w);
    w = rand_word();
    core_write(`CSR_ADR_MCAUSE, w);
    model_write(`CSR_ADR_MCAUSE, w);
    core_write(`CSR_ADR_MSTATUS, '1);
    model_write(`CSR_ADR_MSTATUS, '1);
    check_csrs();
    core_write(12'h7c0, '1);  // unmapped
    core_read(12'h7c0, v);
    check_word("unmapped read", 64'h0, v);
    check_csrs();
    end_test();

    start_test("ecall");
    w = rand_word();
    core_write(`CSR_ADR_MTVEC, w);
    model_write(`CSR_ADR_MTVEC, w);
    core_write(`CSR_ADR_MSTATUS, 64'h8);  // mie only
    model_write(`CSR_ADR_MSTATUS, 64'h8);
    pc = rand_word();
    exp = model_trap(`INST_ECALL, pc);
    do_trap(`INST_ECALL, pc, 0, 1'b0, jmp);
    check_jump("ecall jump", '{valid: 1'b1, addr: exp}, jmp);
    check_csrs();
    end_test();

    start_test("mret");
    exp = model_trap(`INST_MRET, 64'h0);
    do_trap(`INST_MRET, rand_word(), 0, 1'b0, jmp);
    check_jump("mret jump", '{valid: 1'b1, addr: exp}, jmp);
    check_csrs();
    end_test();

    start_test("handshake");
    hold = 4 + ($unsigned($random(seed)) % 12);
    pc = rand_word();
    exp = model_trap(`INST_ECALL, pc);
    do_trap(`INST_ECALL, pc, hold, 1'b1, jmp);
    check_jump("held jump", '{valid: 1'b1, addr: exp}, jmp);
    check_csrs();
    end_test();

    // trap master already owns the bus and keeps winning between its accesses
    start_test("contention");
    w = rand_word();
    pc = rand_word();
    exp = model_trap(`INST_ECALL, pc);
    model_write(`CSR_ADR_MTVEC, w);
    fork
      do_trap(`INST_ECALL, pc, 0, 1'b0, jmp);
      begin
        repeat (4) @(posedge clk);
        core_write(`CSR_ADR_MTVEC, w);
      end
    join
    check_jump("contended jump", '{valid: 1'b1, addr: exp}, jmp);
    check_csrs();
    end_test();

    start_test("random");
    for (int n = 0; n < 20; n++) begin
      op = $random(seed) & 1 ? `INST_ECALL : `INST_MRET;
      pc = rand_word();
      exp = model_trap(op, pc);
      do_trap(op, pc, 0, 1'b0, jmp);
      check_jump($sformatf("jump %0d", n), '{valid: 1'b1, addr: exp}, jmp);
    end
    check_csrs();
    end_test();

    $display("checks done: %0d tests, %0d errors", N_TESTS, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule
